//--- Makefile
# Verilator build and run of the text-mode VGA testbench

VERILATOR ?= verilator
TOP       ?= tb_vga_text
FILELIST  ?= vga_text_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a listed source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q "TEST FAIL" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/vga_axil_slave.sv
/*
 * axi4-lite slave of the text controller
 * handshake state, region decode, write strobes and color readback
 */
`timescale 1ns/1ns

module vga_axil_slave import vga_text_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    // write address and data
    input  logic [AXI_AW-1:0]        s_axil_awaddr_i,
    input  logic                     s_axil_awvalid_i,
    output logic                     s_axil_awready_o,
    input  logic [AXI_DW-1:0]        s_axil_wdata_i,
    input  logic [AXI_DW/8-1:0]      s_axil_wstrb_i,
    input  logic                     s_axil_wvalid_i,
    output logic                     s_axil_wready_o,
    output logic [1:0]               s_axil_bresp_o,
    output logic                     s_axil_bvalid_o,
    input  logic                     s_axil_bready_i,
    // read address and data
    input  logic [AXI_AW-1:0]        s_axil_araddr_i,
    input  logic                     s_axil_arvalid_i,
    output logic                     s_axil_arready_o,
    output logic [AXI_DW-1:0]        s_axil_rdata_o,
    output logic [1:0]               s_axil_rresp_o,
    output logic                     s_axil_rvalid_o,
    input  logic                     s_axil_rready_i,
    // one-cycle write strobes
    output logic                     buf_we_o,
    output cell_t                    buf_idx_o,
    output char_t                    buf_data_o,
    output logic                     font_we_o,
    output font_addr_t               font_idx_o,
    output glyph_row_t               font_data_o,
    output logic                     color_we_o,
    output logic [COLOR_IDX_W-1:0]   color_idx_o,
    output color_t                   color_data_o,
    // color readback
    output logic [COLOR_IDX_W-1:0]   color_rd_idx_o,
    input  color_t                   color_rd_data_i
);

    logic  wr_fire;      // aw and w accepted this cycle
    logic  rd_fire;      // ar accepted this cycle
    logic  wr_en;        // wstrb lane 0 carries the data
    cell_t wr_cell;
    logic  cell_ok;      // inside the 80x30 buffer

    assign wr_fire = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_fire = s_axil_arready_o && s_axil_arvalid_i;
    assign wr_en   = wr_fire && s_axil_wstrb_i[0];
    assign wr_cell = s_axil_awaddr_i[ADDR_LSB +: CELL_W];
    assign cell_ok = (wr_cell < cell_t'(N_CELLS));

    assign s_axil_wready_o = s_axil_awready_o;  // aw and w taken together
    assign s_axil_bresp_o  = RESP_OKAY;
    assign s_axil_rresp_o  = RESP_OKAY;
    assign color_rd_idx_o  = s_axil_araddr_i[ADDR_LSB +: COLOR_IDX_W];

    // ------------------------------------------------------------------
    // handshake and strobe control
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s_axil_awready_o <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
            buf_we_o         <= 1'b0;
            font_we_o        <= 1'b0;
            color_we_o       <= 1'b0;
        end else begin
            // single-cycle ready pulse, held off while a response is pending
            s_axil_awready_o <= !s_axil_awready_o && s_axil_awvalid_i
                                && s_axil_wvalid_i && !s_axil_bvalid_o;
            s_axil_arready_o <= !s_axil_arready_o && s_axil_arvalid_i
                                && !s_axil_rvalid_o;
            if (wr_fire) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
            buf_we_o   <= wr_en && s_axil_awaddr_i[SEL_MSB] && cell_ok;  // drop out of range
            font_we_o  <= wr_en && (s_axil_awaddr_i[SEL_MSB -: 2] == SEL_FONT);
            color_we_o <= wr_en && (s_axil_awaddr_i[SEL_MSB -: 2] == SEL_COLOR);
        end
    end

    // ------------------------------------------------------------------
    // payload, captured at the handshake
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            buf_idx_o    <= wr_cell;
            buf_data_o   <= s_axil_wdata_i[CHAR_W-1:0];      // code truncated to 7 bits
            font_idx_o   <= s_axil_awaddr_i[ADDR_LSB +: FONT_AW];
            font_data_o  <= s_axil_wdata_i[7:0];
            color_idx_o  <= s_axil_awaddr_i[ADDR_LSB +: COLOR_IDX_W];
            color_data_o <= s_axil_wdata_i[COLOR_W-1:0];
        end
        if (rd_fire) begin
            // only the color registers read back, the rest is 0
            s_axil_rdata_o <= (s_axil_araddr_i[SEL_MSB -: 2] == SEL_COLOR) ?
                              AXI_DW'(color_rd_data_i) : '0;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);
    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o);

endmodule

//--- design/vga_color_regs.sv
/*
 * six 4-bit color registers, foreground and background per channel
 * reset to white on black, combinational readback
 */
`timescale 1ns/1ns

module vga_color_regs import vga_text_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   we_i,
    input  logic [COLOR_IDX_W-1:0] idx_i,
    input  color_t                 data_i,
    input  logic [COLOR_IDX_W-1:0] rd_idx_i,
    output color_t                 rd_data_o,
    output rgb_t                   fg_o,
    output rgb_t                   bg_o
);

    localparam int N_REGS   = 6;
    localparam int RED_BG   = 0;
    localparam int RED_FG   = 1;
    localparam int BLUE_BG  = 2;
    localparam int BLUE_FG  = 3;
    localparam int GREEN_BG = 4;
    localparam int GREEN_FG = 5;

    color_t regs_q [N_REGS];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs_q[i] <= (i % 2 == 1) ? '1 : '0;   // odd index is fg, full on
            end
        end else if (we_i && (idx_i < COLOR_IDX_W'(N_REGS))) begin
            regs_q[idx_i] <= data_i;                  // index 6 and 7 dropped
        end
    end

    assign rd_data_o = (rd_idx_i < COLOR_IDX_W'(N_REGS)) ? regs_q[rd_idx_i] : '0;

    assign fg_o = '{red: regs_q[RED_FG], green: regs_q[GREEN_FG], blue: regs_q[BLUE_FG]};
    assign bg_o = '{red: regs_q[RED_BG], green: regs_q[GREEN_BG], blue: regs_q[BLUE_BG]};

endmodule

//--- design/vga_dp_ram.sv
/*
 * simple dual-port ram, one write port and one registered read port
 * payload type set per instance
 */
`timescale 1ns/1ns

module vga_dp_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 256,
    parameter int  AW        = 8
) (
    input  logic          clk_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  payload_t      wdata_i,
    input  logic [AW-1:0] raddr_i,
    output payload_t      rdata_o    // valid one cycle after raddr_i
);

    payload_t mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_o <= mem_q[raddr_i];   // registered read
    end

    // writers range-check upstream, so no write ever lands past the end
    a_waddr_range: assert property (@(posedge clk_i)
        we_i |-> (int'(waddr_i) < DEPTH));

endmodule

//--- design/vga_glyph_fetch.sv
/*
 * glyph fetch pipeline, counters to one glyph bit in two cycles
 * stage 1 reads the char buffer, stage 2 the font memory
 */
`timescale 1ns/1ns

module vga_glyph_fetch import vga_text_pkg::*; #(
    parameter int H_VIS = H_ACTIVE,
    parameter int V_VIS = V_ACTIVE,
    parameter int COLS  = N_COLS,
    parameter int CELLS = N_CELLS
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  cnt_t       hcnt_i,
    input  cnt_t       vcnt_i,
    input  logic       buf_we_i,
    input  cell_t      buf_idx_i,
    input  char_t      buf_data_i,
    input  logic       font_we_i,
    input  font_addr_t font_idx_i,
    input  glyph_row_t font_data_i,
    output logic       glyph_bit_o   // pixel of the counters 2 cycles back
);

    localparam int COL_SH = $clog2(GLYPH_W);   // in-cell column bits
    localparam int ROW_SH = $clog2(GLYPH_H);   // glyph row bits

    logic              in_view;
    cell_t             cell_rd;
    char_t             char_s1;    // char code, stage 1
    font_addr_t        font_rd;
    glyph_row_t        glyph_s2;   // glyph row, stage 2
    logic [ROW_SH-1:0] row_s1;
    logic [COL_SH-1:0] col_s1;
    logic [COL_SH-1:0] col_s2;

    assign in_view = (hcnt_i < cnt_t'(H_VIS)) && (vcnt_i < cnt_t'(V_VIS));
    // row * 80 + column, parked on cell 0 in blanking
    assign cell_rd = in_view ? cell_t'(vcnt_i[CNT_W-1:ROW_SH]) * cell_t'(COLS)
                               + cell_t'(hcnt_i[CNT_W-1:COL_SH]) : '0;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            row_s1 <= '0;
            col_s1 <= '0;
            col_s2 <= '0;
        end else begin
            row_s1 <= vcnt_i[ROW_SH-1:0];    // lines up with char_s1
            col_s1 <= hcnt_i[COL_SH-1:0];
            col_s2 <= col_s1;                // lines up with glyph_s2
        end
    end

    assign font_rd = {char_s1, row_s1};

    vga_dp_ram #(.payload_t(char_t), .DEPTH(CELLS), .AW(CELL_W)) char_ram (
        .clk_i   (clk_i),
        .we_i    (buf_we_i),
        .waddr_i (buf_idx_i),
        .wdata_i (buf_data_i),
        .raddr_i (cell_rd),
        .rdata_o (char_s1)
    );

    vga_dp_ram #(.payload_t(glyph_row_t), .DEPTH(1 << FONT_AW), .AW(FONT_AW)) font_ram (
        .clk_i   (clk_i),
        .we_i    (font_we_i),
        .waddr_i (font_idx_i),
        .wdata_i (font_data_i),
        .raddr_i (font_rd),
        .rdata_o (glyph_s2)
    );

    assign glyph_bit_o = glyph_s2[~col_s2];   // column 0 is bit 7

endmodule

//--- design/vga_pixel_mixer.sv
/*
 * pixel mixer, fg/bg select from the glyph bit, blanking
 * sync alignment and the pmod pin map
 */
`timescale 1ns/1ns

module vga_pixel_mixer import vga_text_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        glyph_bit_i,  // 2 cycles behind the counters
    input  rgb_t        fg_i,
    input  rgb_t        bg_i,
    input  logic        hsync_i,      // straight from the counters
    input  logic        vsync_i,
    input  logic        active_i,
    output logic [15:0] pmod_o
);

    logic [1:0] hs_d;    // 2-cycle delay lines, match the glyph fetch
    logic [1:0] vs_d;
    logic [1:0] act_d;
    rgb_t       pix_d;
    rgb_t       pix_q;
    logic       hs_q;
    logic       vs_q;

    assign pix_d = act_d[1] ? (glyph_bit_i ? fg_i : bg_i) : '0;   // black in blanking

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            hs_d  <= '1;
            vs_d  <= '1;
            act_d <= '0;
            pix_q <= '0;
            hs_q  <= 1'b1;
            vs_q  <= 1'b1;
        end else begin
            hs_d  <= {hs_d[0], hsync_i};
            vs_d  <= {vs_d[0], vsync_i};
            act_d <= {act_d[0], active_i};
            pix_q <= pix_d;
            hs_q  <= hs_d[1];
            vs_q  <= vs_d[1];
        end
    end

    // ------------------------------------------------------------------
    // pmod: blue 3:0, red 7:4, hs 8, vs 9, green 15:12
    assign pmod_o = {pix_q.green, 2'b00, vs_q, hs_q, pix_q.red, pix_q.blue};

    // blanking at the counters shows up on the pins exactly 3 cycles later
    a_blank_align: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !active_i |-> ##3 ({pmod_o[15:12], pmod_o[7:0]} == '0));

endmodule

//--- design/vga_sync_gen.sv
/*
 * horizontal and vertical timing counters
 * sync pulse decode and active-video flag, no added latency
 */
`timescale 1ns/1ns

module vga_sync_gen import vga_text_pkg::*; #(
    parameter int H_VIS    = H_ACTIVE,
    parameter int H_TOT    = H_TOTAL,
    parameter int HS_START = H_SYNC_START,
    parameter int HS_END   = H_SYNC_END,
    parameter int V_VIS    = V_ACTIVE,
    parameter int V_TOT    = V_TOTAL,
    parameter int VS_START = V_SYNC_START,
    parameter int VS_END   = V_SYNC_END
) (
    input  logic clk_i,
    input  logic rstn_i,
    output cnt_t hcnt_o,    // pixel within the line
    output cnt_t vcnt_o,    // line within the frame
    output logic hsync_o,   // active low
    output logic vsync_o,   // active low
    output logic active_o   // visible area
);

    cnt_t hcnt_q;
    cnt_t vcnt_q;
    logic line_end;

    assign line_end = (hcnt_q == cnt_t'(H_TOT - 1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            hcnt_q <= '0;
            vcnt_q <= '0;
        end else if (line_end) begin
            hcnt_q <= '0;                                     // wrap line
            vcnt_q <= (vcnt_q == cnt_t'(V_TOT - 1)) ? '0 : vcnt_q + 1'b1;
        end else begin
            hcnt_q <= hcnt_q + 1'b1;
        end
    end

    assign hcnt_o   = hcnt_q;
    assign vcnt_o   = vcnt_q;
    assign hsync_o  = !((hcnt_q >= cnt_t'(HS_START)) && (hcnt_q < cnt_t'(HS_END)));
    assign vsync_o  = !((vcnt_q >= cnt_t'(VS_START)) && (vcnt_q < cnt_t'(VS_END)));
    assign active_o = (hcnt_q < cnt_t'(H_VIS)) && (vcnt_q < cnt_t'(V_VIS));

    a_hcnt_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        hcnt_q < cnt_t'(H_TOT));

endmodule

//--- design/vga_text_pkg.sv
/*
 * shared definitions of the text-mode vga controller
 * display timing, cell geometry, axi4-lite address map, widths and types
 */
package vga_text_pkg;

    // ------------------------------------------------------------------
    // 640x480 @ 60 Hz, clk_i is the pixel clock
    localparam int H_ACTIVE     = 640;  // visible pixels per line
    localparam int H_TOTAL      = 800;  // pixels per line incl. blanking
    localparam int H_SYNC_START = 656;  // hsync low from here
    localparam int H_SYNC_END   = 752;  // up to here, exclusive
    localparam int V_ACTIVE     = 480;  // visible lines
    localparam int V_TOTAL      = 525;  // lines per frame
    localparam int V_SYNC_START = 490;  // vsync low from here
    localparam int V_SYNC_END   = 492;  // up to here, exclusive

    // ------------------------------------------------------------------
    // character cells
    localparam int GLYPH_W = 8;                  // pixels per cell
    localparam int GLYPH_H = 16;                 // glyph rows per cell
    localparam int N_COLS  = H_ACTIVE / GLYPH_W; // 80
    localparam int N_ROWS  = V_ACTIVE / GLYPH_H; // 30
    localparam int N_CELLS = N_COLS * N_ROWS;    // 2400

    localparam int CNT_W       = 10;  // pixel/line counters
    localparam int CHAR_W      = 7;   // character code
    localparam int CELL_W      = 12;  // cell index
    localparam int FONT_AW     = 11;  // {char code, glyph row}
    localparam int COLOR_W     = 4;
    localparam int COLOR_IDX_W = 3;
    localparam int AXI_AW      = 15;
    localparam int AXI_DW      = 32;

    // ------------------------------------------------------------------
    // address map, region select on bits 14:13, word index from bit 2
    localparam int         SEL_MSB   = 14;     // set alone means char buffer
    localparam int         ADDR_LSB  = 2;      // byte offset bits ignored
    localparam logic [1:0] SEL_COLOR = 2'b01;
    localparam logic [1:0] SEL_FONT  = 2'b00;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [CNT_W-1:0]   cnt_t;
    typedef logic [CHAR_W-1:0]  char_t;
    typedef logic [CELL_W-1:0]  cell_t;
    typedef logic [FONT_AW-1:0] font_addr_t;
    typedef logic [7:0]         glyph_row_t;  // bit 7 is the leftmost pixel
    typedef logic [COLOR_W-1:0] color_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

endpackage

//--- design/vga_text_top.sv
/*
 * top level of the 80x30 text vga controller
 * axi4-lite slave, sync, glyph fetch, color regs and mixer
 */
`timescale 1ns/1ns

module vga_text_top import vga_text_pkg::*; #(
    parameter int H_VIS    = H_ACTIVE,
    parameter int H_TOT    = H_TOTAL,
    parameter int HS_START = H_SYNC_START,
    parameter int HS_END   = H_SYNC_END,
    parameter int V_VIS    = V_ACTIVE,
    parameter int V_TOT    = V_TOTAL,
    parameter int VS_START = V_SYNC_START,
    parameter int VS_END   = V_SYNC_END
) (
    input  logic                clk_i,      // pixel clock
    input  logic                rstn_i,
    input  logic [AXI_AW-1:0]   s_axil_awaddr_i,
    input  logic                s_axil_awvalid_i,
    output logic                s_axil_awready_o,
    input  logic [AXI_DW-1:0]   s_axil_wdata_i,
    input  logic [AXI_DW/8-1:0] s_axil_wstrb_i,
    input  logic                s_axil_wvalid_i,
    output logic                s_axil_wready_o,
    output logic [1:0]          s_axil_bresp_o,
    output logic                s_axil_bvalid_o,
    input  logic                s_axil_bready_i,
    input  logic [AXI_AW-1:0]   s_axil_araddr_i,
    input  logic                s_axil_arvalid_i,
    output logic                s_axil_arready_o,
    output logic [AXI_DW-1:0]   s_axil_rdata_o,
    output logic [1:0]          s_axil_rresp_o,
    output logic                s_axil_rvalid_o,
    input  logic                s_axil_rready_i,
    output logic [15:0]         pmod_o
);

    cnt_t                   hcnt, vcnt;
    logic                   hsync, vsync, active;
    logic                   buf_we, font_we, color_we;
    cell_t                  buf_idx;
    char_t                  buf_data;
    font_addr_t             font_idx;
    glyph_row_t             font_data;
    logic [COLOR_IDX_W-1:0] color_idx, color_rd_idx;
    color_t                 color_data, color_rd_data;
    logic                   glyph_bit;
    rgb_t                   fg, bg;

    vga_sync_gen #(
        .H_VIS(H_VIS), .H_TOT(H_TOT), .HS_START(HS_START), .HS_END(HS_END),
        .V_VIS(V_VIS), .V_TOT(V_TOT), .VS_START(VS_START), .VS_END(VS_END)
    ) u_sync (
        .clk_i(clk_i), .rstn_i(rstn_i), .hcnt_o(hcnt), .vcnt_o(vcnt),
        .hsync_o(hsync), .vsync_o(vsync), .active_o(active)
    );

    vga_axil_slave u_axil (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i),
        .s_axil_awready_o(s_axil_awready_o), .s_axil_wdata_i(s_axil_wdata_i),
        .s_axil_wstrb_i(s_axil_wstrb_i), .s_axil_wvalid_i(s_axil_wvalid_i),
        .s_axil_wready_o(s_axil_wready_o), .s_axil_bresp_o(s_axil_bresp_o),
        .s_axil_bvalid_o(s_axil_bvalid_o), .s_axil_bready_i(s_axil_bready_i),
        .s_axil_araddr_i(s_axil_araddr_i), .s_axil_arvalid_i(s_axil_arvalid_i),
        .s_axil_arready_o(s_axil_arready_o), .s_axil_rdata_o(s_axil_rdata_o),
        .s_axil_rresp_o(s_axil_rresp_o), .s_axil_rvalid_o(s_axil_rvalid_o),
        .s_axil_rready_i(s_axil_rready_i),
        .buf_we_o(buf_we), .buf_idx_o(buf_idx), .buf_data_o(buf_data),
        .font_we_o(font_we), .font_idx_o(font_idx), .font_data_o(font_data),
        .color_we_o(color_we), .color_idx_o(color_idx), .color_data_o(color_data),
        .color_rd_idx_o(color_rd_idx), .color_rd_data_i(color_rd_data)
    );

    vga_glyph_fetch #(
        .H_VIS(H_VIS), .V_VIS(V_VIS), .COLS(N_COLS), .CELLS(N_CELLS)
    ) u_fetch (
        .clk_i(clk_i), .rstn_i(rstn_i), .hcnt_i(hcnt), .vcnt_i(vcnt),
        .buf_we_i(buf_we), .buf_idx_i(buf_idx), .buf_data_i(buf_data),
        .font_we_i(font_we), .font_idx_i(font_idx), .font_data_i(font_data),
        .glyph_bit_o(glyph_bit)
    );

    vga_color_regs u_colors (
        .clk_i(clk_i), .rstn_i(rstn_i), .we_i(color_we), .idx_i(color_idx),
        .data_i(color_data), .rd_idx_i(color_rd_idx), .rd_data_o(color_rd_data),
        .fg_o(fg), .bg_o(bg)
    );

    vga_pixel_mixer u_mixer (
        .clk_i(clk_i), .rstn_i(rstn_i), .glyph_bit_i(glyph_bit), .fg_i(fg), .bg_i(bg),
        .hsync_i(hsync), .vsync_i(vsync), .active_i(active), .pmod_o(pmod_o)
    );

endmodule

//--- verification/tb_vga_model.svh
/*
 * reference model of the text controller for the testbench
 * mirrored buffer, font and colors, expected pixel and sync, compare tasks
 */
`ifndef TB_VGA_MODEL_SVH
`define TB_VGA_MODEL_SVH

char_t      buf_m   [N_CELLS];                  // character codes per cell
glyph_row_t font_m  [1 << FONT_AW];             // {code, glyph row}
color_t     color_m [6] = '{4'h0, 4'hF, 4'h0, 4'hF, 4'h0, 4'hF};  // r/b/g bg,fg pairs
int         value_errs = 0;

// visible pixel from cell, glyph row and column, black elsewhere
function automatic rgb_t expected_pixel(input int h, input int v);
    int         cell_idx;
    glyph_row_t row;
    rgb_t       fg;
    rgb_t       bg;
    fg = '{red: color_m[1], green: color_m[5], blue: color_m[3]};
    bg = '{red: color_m[0], green: color_m[4], blue: color_m[2]};
    if (h >= H_ACTIVE || v >= V_ACTIVE) return '0;
    cell_idx = (v / GLYPH_H) * N_COLS + h / GLYPH_W;
    row      = font_m[{buf_m[cell_idx], 4'(v % GLYPH_H)}];
    return row[7 - h % GLYPH_W] ? fg : bg;     // leftmost pixel is bit 7
endfunction

// sync pins idle high, low inside [lo, hi)
function automatic logic sync_level(input int pos, input int lo, input int hi);
    return !(pos >= lo && pos < hi);
endfunction

task automatic check_rdata(input string name, input logic [AXI_DW-1:0] got, exp);
    if (got !== exp) begin
        value_errs++;
        $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_rgb(input string name, input rgb_t got, exp);
    if (got !== exp) begin
        value_errs++;
        $display("[FAIL] %s got 0x%03h expected 0x%03h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_sync(input string name, input logic got, exp);
    if (got !== exp) begin
        value_errs++;
        $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

`endif

//--- verification/tb_vga_text.sv
/*
 * testbench of the text-mode vga controller
 * axi4-lite driver, pmod monitor against the model, verdict
 */
`timescale 1ns/1ns

module tb_vga_text import vga_text_pkg::*; ();

    localparam int TIMEOUT = 100;                 // cycles per handshake wait
    localparam int FRAME   = H_TOTAL * V_TOTAL;

    logic              clk, rstn;
    logic [AXI_AW-1:0] awaddr, araddr;
    logic [AXI_DW-1:0] wdata, rdata;
    logic [3:0]        wstrb;
    logic [1:0]        bresp, rresp;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [15:0]       pmod;
    integer            seed = 37;
    int                timeout_errs = 0;
    logic              check_active = 1'b0;   // compare visible pixels too
    int                mh = 0;                // model of the dut counters
    int                mv = 0;
    int                hist_h [3] = '{H_TOTAL, H_TOTAL, H_TOTAL};  // 1..3 cycles back
    int                hist_v [3] = '{0, 0, 0};
    int                hs_low = 0;            // running sync-low cycle counts
    int                vs_low = 0;

    `include "tb_vga_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    vga_text_top vga_text_top_inst (
        .clk_i(clk), .rstn_i(rstn),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready), .pmod_o(pmod)
    );

    function automatic logic [AXI_AW-1:0] color_addr(input int idx);
        return AXI_AW'(32'h2000 + idx * 4);
    endfunction

    function automatic logic [AXI_AW-1:0] buf_addr(input int cell_idx);
        return AXI_AW'(32'h4000 + cell_idx * 4);
    endfunction

    function automatic logic [AXI_AW-1:0] font_addr(input int idx);
        return AXI_AW'(idx * 4);
    endfunction

    task automatic timeout_note(input string what, input int cnt, input int limit);
        if (cnt >= limit) begin
            timeout_errs++;
            $display("timeout while waiting for the %s", what);
        end
    endtask

    // ------------------------------------------------------------------
    // axi4-lite master
    task automatic write_issue(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                               input logic [3:0] strb);
        int cnt;
        cnt = 0;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        timeout_note("write address handshake", cnt, TIMEOUT);
        if (awready) begin
            check_sync("wready", wready, 1'b1);   // aw and w taken together
        end
        @(posedge clk);                       // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic collect_bresp();
        int cnt;
        int hold;
        cnt  = 0;
        hold = {$random(seed)} % 4;            // bready withheld 0..3 cycles
        @(negedge clk);
        while (!bvalid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        timeout_note("write response", cnt, TIMEOUT);
        check_rdata("bresp", AXI_DW'(bresp), AXI_DW'(RESP_OKAY));
        check_sync("wready", wready, 1'b0);   // no write taken while a response waits
        repeat (hold) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                              input logic [3:0] strb);
        write_issue(addr, data, strb);
        collect_bresp();
    endtask

    task automatic axil_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
        int cnt;
        int hold;
        cnt  = 0;
        hold = {$random(seed)} % 4;            // rready withheld 0..3 cycles
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        timeout_note("read address handshake", cnt, TIMEOUT);
        @(posedge clk);
        arvalid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!rvalid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        timeout_note("read data", cnt, TIMEOUT);
        data = rdata;
        check_rdata("rresp", AXI_DW'(rresp), AXI_DW'(RESP_OKAY));
        repeat (hold) @(posedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic read_and_compare(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] exp);
        logic [AXI_DW-1:0] data;
        axil_read(addr, data);
        check_rdata("rdata", data, exp);
    endtask

    task automatic wait_position(input int h, input int v);
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (!(mh == h && mv == v) && cnt < FRAME + H_TOTAL) begin
            @(posedge clk);
            cnt++;
        end
        timeout_note("counter position", cnt, FRAME + H_TOTAL);
    endtask

    // ------------------------------------------------------------------
    // pins show the counter position of three cycles back
    always @(negedge clk) begin
        if (rstn) begin
            check_sync("hsync", pmod[8], sync_level(hist_h[2], H_SYNC_START, H_SYNC_END));
            check_sync("vsync", pmod[9], sync_level(hist_v[2], V_SYNC_START, V_SYNC_END));
            check_sync("pmod_10", pmod[10], 1'b0);
            check_sync("pmod_11", pmod[11], 1'b0);
            if (check_active || hist_h[2] >= H_ACTIVE || hist_v[2] >= V_ACTIVE) begin
                check_rgb("pmod_rgb", rgb_t'({pmod[7:4], pmod[15:12], pmod[3:0]}),
                          expected_pixel(hist_h[2], hist_v[2]));   // blanking always checked
            end
            hs_low += int'(!pmod[8]);
            vs_low += int'(!pmod[9]);
            for (int i = 2; i > 0; i--) begin
                hist_h[i] = hist_h[i-1];
                hist_v[i] = hist_v[i-1];
            end
            hist_h[0] = mh;
            hist_v[0] = mv;
            if (mh == H_TOTAL - 1) begin
                mh = 0;
                mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
            end else begin
                mh++;
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    initial begin
        logic [AXI_DW-1:0] data;
        logic [3:0]        strb;
        int                idx;
        int                hs_mark;
        int                vs_mark;
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        // reset defaults, only the color registers read back
        for (int i = 0; i < 6; i++) begin
            read_and_compare(color_addr(i), AXI_DW'(color_m[i]));
        end
        read_and_compare(color_addr(6), '0);
        read_and_compare(buf_addr(5), '0);
        read_and_compare(font_addr(5), '0);

        for (int i = 0; i < 16; i++) begin
            idx  = {$random(seed)} % 6;
            data = $random(seed);
            strb = 4'($random(seed));
            axil_write(color_addr(idx), data, strb);
            if (strb[0]) begin
                color_m[idx] = data[COLOR_W-1:0];    // lane 0 only
            end
            read_and_compare(color_addr(idx), AXI_DW'(color_m[idx]));
        end
        axil_write(color_addr(1), AXI_DW'(~color_m[1]), 4'b1110);
        read_and_compare(color_addr(1), AXI_DW'(color_m[1]));

        // second write held off behind an unanswered response
        write_issue(color_addr(2), AXI_DW'(color_m[2] ^ 4'h9), 4'h1);
        fork
            write_issue(color_addr(3), AXI_DW'(color_m[3] ^ 4'h6), 4'h1);
            begin
                repeat (8) @(posedge clk);
                collect_bresp();
            end
        join
        collect_bresp();
        color_m[2] = color_m[2] ^ 4'h9;
        color_m[3] = color_m[3] ^ 4'h6;
        read_and_compare(color_addr(2), AXI_DW'(color_m[2]));
        read_and_compare(color_addr(3), AXI_DW'(color_m[3]));

        // whole font, first two text rows, random colors
        for (int i = 0; i < (1 << FONT_AW); i++) begin
            data = $random(seed);
            axil_write(font_addr(i) | AXI_AW'(i % 4), data, 4'h1);   // byte offset ignored
            font_m[i] = data[7:0];
        end
        for (int i = 0; i < 2 * N_COLS; i++) begin
            data = $random(seed);
            axil_write(buf_addr(i), data, 4'hF);
            buf_m[i] = data[CHAR_W-1:0];
        end
        for (int i = 0; i < 6; i++) begin
            data = $random(seed);
            axil_write(color_addr(i), data, 4'h1);
            color_m[i] = data[COLOR_W-1:0];
        end
        axil_write(buf_addr(N_CELLS), 32'h7F, 4'h1);    // past the buffer, dropped
        axil_write(buf_addr(4095), 32'h7F, 4'h1);

        wait_position(0, 0);
        hs_mark      = hs_low;
        vs_mark      = vs_low;
        check_active = 1'b1;
        wait_position(0, 2 * GLYPH_H);
        check_active = 1'b0;
        wait_position(0, 0);
        check_rdata("hsync_low_cycles", hs_low - hs_mark, (H_SYNC_END - H_SYNC_START) * V_TOTAL);
        check_rdata("vsync_low_cycles", vs_low - vs_mark, (V_SYNC_END - V_SYNC_START) * H_TOTAL);

        $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vga_text_top.f
+incdir+verification
design/vga_text_pkg.sv
design/vga_sync_gen.sv
design/vga_axil_slave.sv
design/vga_dp_ram.sv
design/vga_glyph_fetch.sv
design/vga_color_regs.sv
design/vga_pixel_mixer.sv
design/vga_text_top.sv
verification/tb_vga_text.sv
